/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_accum_warp_looper
RTL_TOP    ?= accum_warp_looper
FILELIST   ?= accum_warp_looper.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= -Wall

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --timing --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: build
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then echo "No result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* accum_warp_looper.f */
+incdir+include
verilog/awl_pkg.sv
verilog/awl_cfg_regs.sv
verilog/awl_offset_stage.sv
verilog/awl_memofs_stage.sv
verilog/awl_vector_stage.sv
verilog/accum_warp_looper.sv
test/tb_accum_warp_looper.sv

/* include/awl_params.svh */
`ifndef AWL_PARAMS_SVH
`define AWL_PARAMS_SVH

// Range dimensions walked per request
`define AWL_DIM 2

// Lanes in one output address vector
`define AWL_VSIZE 4

// Offset word and address widths
`define AWL_WBW 8
`define AWL_ABW 16

// Config sets held by the register block
`define AWL_N_CFG 4

// Stride shift amount width
`define AWL_SS_BW 4

`endif

/* test/tb_accum_warp_looper.sv */
`timescale 1ns/1ps
`include "awl_params.svh"

module tb_accum_warp_looper;
	import awl_pkg::*;

	localparam int SEED = 32'h8592;
	localparam int DEPTH = 256;
	// Item counts of the five tests, the random test at its largest range
	localparam int TOTAL_ITEMS = 6 + 10 + 12 + 6 * 16 + 2;
	localparam int WATCHDOG_CYCLES = 4 * TOTAL_ITEMS + 200;

	typedef struct packed {
		cfg_id_t    id;
		addr_vec_t  address;
		lane_mask_t valid;
		logic       retire;
	} item_t;

	logic       i_clk;
	logic       i_rst;
	logic       i_cfg_we;
	cfg_id_t    i_cfg_id;
	cfg_field_e i_cfg_field;
	addr_t      i_cfg_wdata;
	logic       i_abofs_rdy;
	logic       o_abofs_ack;
	cfg_id_t    i_id;
	ofs_vec_t   i_bofs;
	ofs_vec_t   i_abeg;
	ofs_vec_t   i_aend;
	logic       o_addrval_rdy;
	logic       i_addrval_ack;
	cfg_id_t    o_id;
	addr_vec_t  o_address;
	lane_mask_t o_valid;
	logic       o_retire;

	// Config values as the TB programmed them
	addr_t  cfg_linear   [`AWL_N_CFG];
	shamt_t cfg_shamt0   [`AWL_N_CFG];
	shamt_t cfg_shamt1   [`AWL_N_CFG];
	addr_t  cfg_step     [`AWL_N_CFG];
	ofs_t   cfg_boundary [`AWL_N_CFG];

	// Reference queue of expected output items
	item_t      exp_mem [DEPTH];
	logic [7:0] wr_idx = '0;
	logic [7:0] rd_idx = '0;
	item_t      head;
	logic       xfer;

	int    errors = 0;
	string test_name = "reset";
	logic  rand_ack = 1'b0;
	logic  req_empty = 1'b0;

	accum_warp_looper dut0 (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_cfg_we      (i_cfg_we),
		.i_cfg_id      (i_cfg_id),
		.i_cfg_field   (i_cfg_field),
		.i_cfg_wdata   (i_cfg_wdata),
		.i_abofs_rdy   (i_abofs_rdy),
		.o_abofs_ack   (o_abofs_ack),
		.i_id          (i_id),
		.i_bofs        (i_bofs),
		.i_abeg        (i_abeg),
		.i_aend        (i_aend),
		.o_addrval_rdy (o_addrval_rdy),
		.i_addrval_ack (i_addrval_ack),
		.o_id          (o_id),
		.o_address     (o_address),
		.o_valid       (o_valid),
		.o_retire      (o_retire)
	);

	initial begin
		i_clk = 1'b0;
		forever #10 i_clk = ~i_clk;
	end

	// Output ack, only offered while an item is ready
	initial begin
		i_addrval_ack = 1'b0;
		forever begin
			@(posedge i_clk);
			#1;
			if (rand_ack)
				i_addrval_ack = o_addrval_rdy && (($urandom % 2) == 0);
			else
				i_addrval_ack = o_addrval_rdy;
		end
	end

	assign head = exp_mem[rd_idx];
	assign xfer = o_addrval_rdy && i_addrval_ack;

	always @(posedge i_clk) begin
		if (!i_rst && xfer)
			rd_idx <= rd_idx + 1'b1;
	end

	//======================================================================
	// Reference model
	//======================================================================
	task automatic push_items(input cfg_id_t id, input ofs_t b0, input ofs_t b1,
			input ofs_t g0, input ofs_t g1, input ofs_t e0, input ofs_t e1);
		item_t it;
		ofs_t  o0;
		ofs_t  o1;
		addr_t lin;
		// Row-major walk, dimension 0 fastest
		for (int i1 = int'(g1); i1 < int'(e1); i1++) begin
			for (int i0 = int'(g0); i0 < int'(e0); i0++) begin
				o0 = b0 + ofs_t'(i0);
				o1 = b1 + ofs_t'(i1);
				lin = cfg_linear[id] + (addr_t'(o0) << cfg_shamt0[id]);
				lin = lin + (addr_t'(o1) << cfg_shamt1[id]);
				it.id = id;
				for (int k = 0; k < `AWL_VSIZE; k++) begin
					it.address[k] = lin + addr_t'(k) * cfg_step[id];
					it.valid[k] = (int'(o0) + k) < int'(cfg_boundary[id]);
				end
				it.retire = (i0 == int'(e0) - 1) && (i1 == int'(e1) - 1);
				exp_mem[wr_idx] = it;
				wr_idx = wr_idx + 1'b1;
			end
		end
	endtask

	//======================================================================
	// Stimulus tasks
	//======================================================================
	task automatic program_cfg(input cfg_id_t id, input addr_t linear, input shamt_t sh0,
			input shamt_t sh1, input addr_t step, input ofs_t bnd);
		@(posedge i_clk);
		#1;
		i_cfg_we = 1'b1;
		i_cfg_id = id;
		i_cfg_field = CFG_LINEAR;
		i_cfg_wdata = linear;
		@(posedge i_clk);
		#1;
		i_cfg_field = CFG_SHAMT0;
		i_cfg_wdata = addr_t'(sh0);
		@(posedge i_clk);
		#1;
		i_cfg_field = CFG_SHAMT1;
		i_cfg_wdata = addr_t'(sh1);
		@(posedge i_clk);
		#1;
		i_cfg_field = CFG_LANE_STEP;
		i_cfg_wdata = step;
		@(posedge i_clk);
		#1;
		i_cfg_field = CFG_BOUNDARY;
		i_cfg_wdata = addr_t'(bnd);
		@(posedge i_clk);
		#1;
		i_cfg_we = 1'b0;
		cfg_linear[id] = linear;
		cfg_shamt0[id] = sh0;
		cfg_shamt1[id] = sh1;
		cfg_step[id] = step;
		cfg_boundary[id] = bnd;
	endtask

	task automatic send_req(input cfg_id_t id, input ofs_t b0, input ofs_t b1,
			input ofs_t g0, input ofs_t g1, input ofs_t e0, input ofs_t e1);
		@(posedge i_clk);
		#1;
		push_items(id, b0, b1, g0, g1, e0, e1);
		req_empty = (g0 >= e0) || (g1 >= e1);
		i_id = id;
		i_bofs[0] = b0;
		i_bofs[1] = b1;
		i_abeg[0] = g0;
		i_abeg[1] = g1;
		i_aend[0] = e0;
		i_aend[1] = e1;
		i_abofs_rdy = 1'b1;
		// Hold the request until its ack
		do @(negedge i_clk); while (!o_abofs_ack);
		@(posedge i_clk);
		#1;
		i_abofs_rdy = 1'b0;
	endtask

	//======================================================================
	// Checks
	//======================================================================
	a_id: assert property (@(posedge i_clk) disable iff (i_rst) xfer |-> o_id == head.id)
		else begin
			errors++;
			$display("CHECK FAILED %s: id expected %0d actual %0d",
				test_name, $sampled(head.id), $sampled(o_id));
		end

	a_address: assert property (@(posedge i_clk) disable iff (i_rst)
		xfer |-> o_address == head.address)
		else begin
			errors++;
			$display("CHECK FAILED %s: address expected %h actual %h",
				test_name, $sampled(head.address), $sampled(o_address));
		end

	a_valid: assert property (@(posedge i_clk) disable iff (i_rst)
		xfer |-> o_valid == head.valid)
		else begin
			errors++;
			$display("CHECK FAILED %s: valid expected %b actual %b",
				test_name, $sampled(head.valid), $sampled(o_valid));
		end

	a_retire: assert property (@(posedge i_clk) disable iff (i_rst)
		xfer |-> o_retire == head.retire)
		else begin
			errors++;
			$display("CHECK FAILED %s: retire expected %b actual %b",
				test_name, $sampled(head.retire), $sampled(o_retire));
		end

	a_no_extra: assert property (@(posedge i_clk) disable iff (i_rst) xfer |-> rd_idx < wr_idx)
		else begin
			errors++;
			$display("%s: output item that the reference queue does not hold", test_name);
		end

	a_hold: assert property (@(posedge i_clk) disable iff (i_rst)
		o_addrval_rdy && !i_addrval_ack |=> o_addrval_rdy && $stable(o_id)
			&& $stable(o_address) && $stable(o_valid) && $stable(o_retire))
		else begin
			errors++;
			$display("%s: output changed while it waited for ack", test_name);
		end

	// Three register stages between request and output
	a_first_out: assert property (@(posedge i_clk) disable iff (i_rst)
		$rose(i_abofs_rdy) && !req_empty && !rand_ack |->
			!o_addrval_rdy ##1 !o_addrval_rdy ##1 !o_addrval_rdy ##1 o_addrval_rdy)
		else begin
			errors++;
			$display("%s: first output did not come 3 cycles after the request", test_name);
		end

	a_stream: assert property (@(posedge i_clk) disable iff (i_rst)
		o_addrval_rdy && !o_retire && !rand_ack |=> o_addrval_rdy)
		else begin
			errors++;
			$display("%s: gap in the output stream under constant ack", test_name);
		end

	a_ack_after_retire: assert property (@(posedge i_clk) disable iff (i_rst)
		xfer && o_retire |=> o_abofs_ack)
		else begin
			errors++;
			$display("%s: request ack missing after the last item", test_name);
		end

	a_ack_not_early: assert property (@(posedge i_clk) disable iff (i_rst)
		o_abofs_ack |-> rd_idx == wr_idx)
		else begin
			errors++;
			$display("%s: request acked before all its items left", test_name);
		end

	a_empty_ack: assert property (@(posedge i_clk) disable iff (i_rst)
		$rose(i_abofs_rdy) && req_empty |=> o_abofs_ack)
		else begin
			errors++;
			$display("%s: empty range not acked one cycle after the request", test_name);
		end

	a_reset_low: assert property (@(posedge i_clk)
		$fell(i_rst) |-> !o_abofs_ack && !o_addrval_rdy && !o_retire)
		else begin
			errors++;
			$display("handshake outputs not low after reset");
		end

	//======================================================================
	// Test sequence
	//======================================================================
	initial begin
		cfg_id_t rid;
		ofs_t    rb0;
		ofs_t    rb1;
		ofs_t    rg0;
		ofs_t    rg1;
		ofs_t    re0;
		ofs_t    re1;
		void'($urandom(SEED));
		i_rst = 1'b1;
		i_cfg_we = 1'b0;
		i_cfg_id = '0;
		i_cfg_field = CFG_LINEAR;
		i_cfg_wdata = '0;
		i_abofs_rdy = 1'b0;
		i_id = '0;
		i_bofs = '0;
		i_abeg = '0;
		i_aend = '0;
		for (int c = 0; c < `AWL_N_CFG; c++) begin
			cfg_linear[c] = '0;
			cfg_shamt0[c] = '0;
			cfg_shamt1[c] = '0;
			cfg_step[c] = '0;
			cfg_boundary[c] = '0;
		end
		repeat (3) @(posedge i_clk);
		#1;
		i_rst = 1'b0;

		test_name = "row_major";
		program_cfg(2'd0, 16'h0100, 4'd1, 4'd4, 16'h0002, 8'hff);
		send_req(2'd0, 8'd2, 8'd3, 8'd0, 8'd0, 8'd3, 8'd2);

		// Boundary sits inside the walked range
		test_name = "boundary";
		program_cfg(2'd1, 16'h0040, 4'd0, 4'd3, 16'h0001, 8'd6);
		send_req(2'd1, 8'd1, 8'd0, 8'd0, 8'd0, 8'd5, 8'd2);

		test_name = "multi_cfg";
		program_cfg(2'd2, 16'h2000, 4'd2, 4'd5, 16'h0010, 8'd4);
		program_cfg(2'd3, 16'h8000, 4'd3, 4'd0, 16'h0100, 8'd9);
		send_req(2'd2, 8'd0, 8'd1, 8'd1, 8'd0, 8'd3, 8'd3);
		send_req(2'd3, 8'd4, 8'd4, 8'd0, 8'd2, 8'd2, 8'd4);
		send_req(2'd0, 8'd5, 8'd0, 8'd0, 8'd0, 8'd2, 8'd1);

		test_name = "random_ack";
		rand_ack = 1'b1;
		for (int r = 0; r < 6; r++) begin
			rid = cfg_id_t'($urandom % `AWL_N_CFG);
			rb0 = ofs_t'($urandom % 16);
			rb1 = ofs_t'($urandom % 16);
			rg0 = ofs_t'($urandom % 4);
			rg1 = ofs_t'($urandom % 4);
			re0 = rg0 + ofs_t'(1 + ($urandom % 4));
			re1 = rg1 + ofs_t'(1 + ($urandom % 4));
			send_req(rid, rb0, rb1, rg0, rg1, re0, re1);
		end
		rand_ack = 1'b0;

		test_name = "empty_range";
		send_req(2'd0, 8'd0, 8'd0, 8'd2, 8'd0, 8'd2, 8'd3);
		send_req(2'd1, 8'd3, 8'd2, 8'd0, 8'd1, 8'd1, 8'd3);

		repeat (4) @(posedge i_clk);
		if (rd_idx != wr_idx) begin
			errors++;
			$display("CHECK FAILED end_of_run: items expected %0d actual %0d", wr_idx, rd_idx);
		end
		$display("Run finished with %0d error(s)", errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge i_clk);
		$display("Timeout after %0d cycles, the run did not reach its end", WATCHDOG_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

/* verilog/accum_warp_looper.sv */
`timescale 1ns/1ps

module accum_warp_looper (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  i_cfg_we,
	input  awl_pkg::cfg_id_t      i_cfg_id,
	input  awl_pkg::cfg_field_e   i_cfg_field,
	input  awl_pkg::addr_t        i_cfg_wdata,
	input  logic                  i_abofs_rdy,
	output logic                  o_abofs_ack,
	input  awl_pkg::cfg_id_t      i_id,
	input  awl_pkg::ofs_vec_t     i_bofs,
	input  awl_pkg::ofs_vec_t     i_abeg,
	input  awl_pkg::ofs_vec_t     i_aend,
	output logic                  o_addrval_rdy,
	input  logic                  i_addrval_ack,
	output awl_pkg::cfg_id_t      o_id,
	output awl_pkg::addr_vec_t    o_address,
	output awl_pkg::lane_mask_t   o_valid,
	output logic                  o_retire
);
	import awl_pkg::*;

	//======================================================================
	// Stage links
	//======================================================================
	// Offset stage to memofs stage
	logic     s01_rdy;
	logic     s01_ack;
	cfg_id_t  s01_id;
	ofs_vec_t s01_ofs;
	logic     s01_retire;

	// Memofs stage to vector stage
	logic     s12_rdy;
	logic     s12_ack;
	cfg_id_t  s12_id;
	addr_t    s12_linear;
	ofs_t     s12_ofs0;
	logic     s12_retire;

	// Config reads and the finish pulse
	cfg_id_t  m_id;
	cfg_id_t  v_id;
	addr_t    m_linear;
	shamt_t   m_shamt0;
	shamt_t   m_shamt1;
	addr_t    v_lane_step;
	ofs_t     v_boundary;
	logic     fin;

	awl_cfg_regs u_cfg (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_cfg_we      (i_cfg_we),
		.i_cfg_id      (i_cfg_id),
		.i_cfg_field   (i_cfg_field),
		.i_cfg_wdata   (i_cfg_wdata),
		.i_m_id        (m_id),
		.i_v_id        (v_id),
		.o_m_linear    (m_linear),
		.o_m_shamt0    (m_shamt0),
		.o_m_shamt1    (m_shamt1),
		.o_v_lane_step (v_lane_step),
		.o_v_boundary  (v_boundary)
	);

	awl_offset_stage u_s0_ofs (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_abofs_rdy (i_abofs_rdy),
		.o_abofs_ack (o_abofs_ack),
		.i_id        (i_id),
		.i_bofs      (i_bofs),
		.i_abeg      (i_abeg),
		.i_aend      (i_aend),
		.o_dst_rdy   (s01_rdy),
		.i_dst_ack   (s01_ack),
		.o_id        (s01_id),
		.o_ofs       (s01_ofs),
		.o_retire    (s01_retire),
		.i_fin       (fin)
	);

	awl_memofs_stage u_s1_mofs (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_src_rdy (s01_rdy),
		.o_src_ack (s01_ack),
		.i_id      (s01_id),
		.i_ofs     (s01_ofs),
		.i_retire  (s01_retire),
		.o_m_id    (m_id),
		.i_linear  (m_linear),
		.i_shamt0  (m_shamt0),
		.i_shamt1  (m_shamt1),
		.o_dst_rdy (s12_rdy),
		.i_dst_ack (s12_ack),
		.o_id      (s12_id),
		.o_linear  (s12_linear),
		.o_ofs0    (s12_ofs0),
		.o_retire  (s12_retire)
	);

	awl_vector_stage u_s2_vec (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_src_rdy     (s12_rdy),
		.o_src_ack     (s12_ack),
		.i_id          (s12_id),
		.i_linear      (s12_linear),
		.i_ofs0        (s12_ofs0),
		.i_retire      (s12_retire),
		.o_v_id        (v_id),
		.i_lane_step   (v_lane_step),
		.i_boundary    (v_boundary),
		.o_addrval_rdy (o_addrval_rdy),
		.i_addrval_ack (i_addrval_ack),
		.o_id          (o_id),
		.o_address     (o_address),
		.o_valid       (o_valid),
		.o_retire      (o_retire),
		.o_fin         (fin)
	);

endmodule

/* verilog/awl_cfg_regs.sv */
`timescale 1ns/1ps
`include "awl_params.svh"

module awl_cfg_regs (
	input  logic                   i_clk,
	input  logic                   i_rst,
	input  logic                   i_cfg_we,
	input  awl_pkg::cfg_id_t       i_cfg_id,
	input  awl_pkg::cfg_field_e    i_cfg_field,
	input  awl_pkg::addr_t         i_cfg_wdata,
	input  awl_pkg::cfg_id_t       i_m_id,
	input  awl_pkg::cfg_id_t       i_v_id,
	output awl_pkg::addr_t         o_m_linear,
	output awl_pkg::shamt_t        o_m_shamt0,
	output awl_pkg::shamt_t        o_m_shamt1,
	output awl_pkg::addr_t         o_v_lane_step,
	output awl_pkg::ofs_t          o_v_boundary
);
	import awl_pkg::*;

	//======================================================================
	// Per-config storage
	//======================================================================
	addr_t  linear    [`AWL_N_CFG];
	shamt_t shamt0    [`AWL_N_CFG];
	shamt_t shamt1    [`AWL_N_CFG];
	addr_t  lane_step [`AWL_N_CFG];
	ofs_t   boundary  [`AWL_N_CFG];

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int c = 0; c < `AWL_N_CFG; c++) begin
				linear[c]    <= '0;
				shamt0[c]    <= '0;
				shamt1[c]    <= '0;
				lane_step[c] <= '0;
				boundary[c]  <= '0;
			end
		end else if (i_cfg_we) begin
			case (i_cfg_field)
				CFG_LINEAR:    linear[i_cfg_id]    <= i_cfg_wdata;
				CFG_SHAMT0:    shamt0[i_cfg_id]    <= i_cfg_wdata[`AWL_SS_BW-1:0];
				CFG_SHAMT1:    shamt1[i_cfg_id]    <= i_cfg_wdata[`AWL_SS_BW-1:0];
				CFG_LANE_STEP: lane_step[i_cfg_id] <= i_cfg_wdata;
				CFG_BOUNDARY:  boundary[i_cfg_id]  <= i_cfg_wdata[`AWL_WBW-1:0];
				default: ;
			endcase
		end
	end

	//======================================================================
	// Read ports
	//======================================================================
	// Memofs stage port
	assign o_m_linear = linear[i_m_id];
	assign o_m_shamt0 = shamt0[i_m_id];
	assign o_m_shamt1 = shamt1[i_m_id];

	// Vector stage port
	assign o_v_lane_step = lane_step[i_v_id];
	assign o_v_boundary  = boundary[i_v_id];

	// Unused encodings of the field select would drop the write
	a_cfg_field_legal: assert property (@(posedge i_clk) disable iff (i_rst)
		i_cfg_we |-> (i_cfg_field <= CFG_BOUNDARY))
		else $error("config write to unknown field %0d", i_cfg_field);

endmodule

/* verilog/awl_memofs_stage.sv */
`timescale 1ns/1ps

module awl_memofs_stage (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_src_rdy,
	output logic                 o_src_ack,
	input  awl_pkg::cfg_id_t     i_id,
	input  awl_pkg::ofs_vec_t    i_ofs,
	input  logic                 i_retire,
	output awl_pkg::cfg_id_t     o_m_id,
	input  awl_pkg::addr_t       i_linear,
	input  awl_pkg::shamt_t      i_shamt0,
	input  awl_pkg::shamt_t      i_shamt1,
	output logic                 o_dst_rdy,
	input  logic                 i_dst_ack,
	output awl_pkg::cfg_id_t     o_id,
	output awl_pkg::addr_t       o_linear,
	output awl_pkg::ofs_t        o_ofs0,
	output logic                 o_retire
);
	import awl_pkg::*;

	addr_t sh0;
	addr_t sh1;
	addr_t linear_sum;

	//======================================================================
	// Linear address
	//======================================================================
	// Config lookup follows the item waiting at the input
	assign o_m_id = i_id;

	always_comb begin
		sh0 = addr_t'(i_ofs[0]) << i_shamt0;
		sh1 = addr_t'(i_ofs[1]) << i_shamt1;
		linear_sum = i_linear + sh0 + sh1;
	end

	//======================================================================
	// Pipeline register
	//======================================================================
	// Take a new item when empty or when the held one leaves this cycle
	assign o_src_ack = i_src_rdy && (!o_dst_rdy || i_dst_ack);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_dst_rdy <= 1'b0;
		end else if (o_src_ack) begin
			o_dst_rdy <= 1'b1;
		end else if (i_dst_ack) begin
			o_dst_rdy <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_src_ack) begin
			o_id     <= i_id;
			o_linear <= linear_sum;
			o_ofs0   <= i_ofs[0];
			o_retire <= i_retire;
		end
	end

endmodule

/* verilog/awl_offset_stage.sv */
`timescale 1ns/1ps
`include "awl_params.svh"

module awl_offset_stage (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_abofs_rdy,
	output logic                 o_abofs_ack,
	input  awl_pkg::cfg_id_t     i_id,
	input  awl_pkg::ofs_vec_t    i_bofs,
	input  awl_pkg::ofs_vec_t    i_abeg,
	input  awl_pkg::ofs_vec_t    i_aend,
	output logic                 o_dst_rdy,
	input  logic                 i_dst_ack,
	output awl_pkg::cfg_id_t     o_id,
	output awl_pkg::ofs_vec_t    o_ofs,
	output logic                 o_retire,
	input  logic                 i_fin
);
	import awl_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_WALK, ST_WAIT, ST_ACK} state_e;

	state_e   state;
	ofs_vec_t r_bofs;
	ofs_vec_t r_aend;
	ofs_t     r_abeg0;
	ofs_vec_t cnt;
	ofs_vec_t nxt_cnt;
	ofs_vec_t first_sum;
	ofs_vec_t nxt_sum;
	logic     empty;
	logic     first_last;
	logic     nxt_last;
	logic     start;
	logic     step;

	//======================================================================
	// Range walk
	//======================================================================
	always_comb begin
		empty = 1'b0;
		for (int d = 0; d < `AWL_DIM; d++) begin
			if (i_abeg[d] >= i_aend[d])
				empty = 1'b1;
			first_sum[d] = i_bofs[d] + i_abeg[d];
		end
		first_last = (i_abeg[0] + 1'b1 == i_aend[0]) && (i_abeg[1] + 1'b1 == i_aend[1]);

		// Dimension 0 wraps back to its begin and carries into dimension 1
		if (cnt[0] + 1'b1 == r_aend[0]) begin
			nxt_cnt[0] = r_abeg0;
			nxt_cnt[1] = cnt[1] + 1'b1;
		end else begin
			nxt_cnt[0] = cnt[0] + 1'b1;
			nxt_cnt[1] = cnt[1];
		end
		for (int d = 0; d < `AWL_DIM; d++)
			nxt_sum[d] = r_bofs[d] + nxt_cnt[d];
		nxt_last = (nxt_cnt[0] + 1'b1 == r_aend[0]) && (nxt_cnt[1] + 1'b1 == r_aend[1]);
	end

	assign start = (state == ST_IDLE) && i_abofs_rdy && !empty;
	assign step  = (state == ST_WALK) && i_dst_ack && !o_retire;
	assign o_abofs_ack = (state == ST_ACK);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state     <= ST_IDLE;
			o_dst_rdy <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					// Empty range skips straight to the request ack
					if (i_abofs_rdy && empty) begin
						state <= ST_ACK;
					end else if (i_abofs_rdy) begin
						state     <= ST_WALK;
						o_dst_rdy <= 1'b1;
					end
				end
				ST_WALK: begin
					if (i_dst_ack && o_retire) begin
						state     <= ST_WAIT;
						o_dst_rdy <= 1'b0;
					end
				end
				ST_WAIT: if (i_fin) state <= ST_ACK;
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (start) begin
			r_bofs   <= i_bofs;
			r_aend   <= i_aend;
			r_abeg0  <= i_abeg[0];
			cnt      <= i_abeg;
			o_id     <= i_id;
			o_ofs    <= first_sum;
			o_retire <= first_last;
		end else if (step) begin
			cnt      <= nxt_cnt;
			o_ofs    <= nxt_sum;
			o_retire <= nxt_last;
		end
	end

	a_dst_hold: assert property (@(posedge i_clk) disable iff (i_rst)
		o_dst_rdy && !i_dst_ack |=>
			o_dst_rdy && $stable(o_id) && $stable(o_ofs) && $stable(o_retire))
		else $error("offset stage output changed before ack");

	// Finish only comes back for a request still waiting on its last item
	a_fin_active: assert property (@(posedge i_clk) disable iff (i_rst)
		i_fin |-> (state == ST_WAIT))
		else $error("fin pulse without an active request");

endmodule

/* verilog/awl_pkg.sv */
`include "awl_params.svh"

package awl_pkg;

	// Config index
	typedef logic [$clog2(`AWL_N_CFG)-1:0] cfg_id_t;

	// Offsets, one word per dimension
	typedef logic [`AWL_WBW-1:0] ofs_t;
	typedef ofs_t [`AWL_DIM-1:0] ofs_vec_t;

	// Addresses, one per lane
	typedef logic [`AWL_ABW-1:0] addr_t;
	typedef addr_t [`AWL_VSIZE-1:0] addr_vec_t;

	typedef logic [`AWL_VSIZE-1:0] lane_mask_t;
	typedef logic [`AWL_SS_BW-1:0] shamt_t;

	// Field chosen by a config write
	typedef enum logic [2:0] {
		CFG_LINEAR,
		CFG_SHAMT0,
		CFG_SHAMT1,
		CFG_LANE_STEP,
		CFG_BOUNDARY
	} cfg_field_e;

endpackage

/* verilog/awl_vector_stage.sv */
`timescale 1ns/1ps
`include "awl_params.svh"

module awl_vector_stage (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  i_src_rdy,
	output logic                  o_src_ack,
	input  awl_pkg::cfg_id_t      i_id,
	input  awl_pkg::addr_t        i_linear,
	input  awl_pkg::ofs_t         i_ofs0,
	input  logic                  i_retire,
	output awl_pkg::cfg_id_t      o_v_id,
	input  awl_pkg::addr_t        i_lane_step,
	input  awl_pkg::ofs_t         i_boundary,
	output logic                  o_addrval_rdy,
	input  logic                  i_addrval_ack,
	output awl_pkg::cfg_id_t      o_id,
	output awl_pkg::addr_vec_t    o_address,
	output awl_pkg::lane_mask_t   o_valid,
	output logic                  o_retire,
	output logic                  o_fin
);
	import awl_pkg::*;

	// Lane offset needs room for the lane index without wrapping
	localparam int LOFS_BW = `AWL_WBW + $clog2(`AWL_VSIZE) + 1;

	addr_vec_t  lane_addr;
	lane_mask_t lane_valid;

	assign o_v_id = i_id;

	//======================================================================
	// Lane expansion
	//======================================================================
	always_comb begin
		logic [LOFS_BW-1:0] lane_ofs;
		for (int k = 0; k < `AWL_VSIZE; k++) begin
			lane_addr[k] = i_linear + addr_t'(k) * i_lane_step;
			lane_ofs = LOFS_BW'(i_ofs0) + LOFS_BW'(k);
			lane_valid[k] = lane_ofs < LOFS_BW'(i_boundary);
		end
	end

	assign o_src_ack = i_src_rdy && (!o_addrval_rdy || i_addrval_ack);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_addrval_rdy <= 1'b0;
			o_retire      <= 1'b0;
		end else if (o_src_ack) begin
			o_addrval_rdy <= 1'b1;
			o_retire      <= i_retire;
		end else if (i_addrval_ack) begin
			o_addrval_rdy <= 1'b0;
			o_retire      <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_src_ack) begin
			o_id      <= i_id;
			o_address <= lane_addr;
			o_valid   <= lane_valid;
		end
	end

	// Last item of a request has left the looper
	assign o_fin = o_addrval_rdy && i_addrval_ack && o_retire;

	// Nothing of the same request may queue behind its last item
	a_fin_retire: assert property (@(posedge i_clk) disable iff (i_rst)
		o_fin |-> !i_src_rdy)
		else $error("item queued behind the last item of a request");

endmodule
